// File: rtl/host_pkg.sv
package host_pkg;

	// Disk command as seen by the host
	// op_none means nothing is pending
	typedef enum logic [1:0] {
		op_none  = 2'd0,
		op_read  = 2'd1,
		op_write = 2'd2
	} disk_op_e;

	// Emulated drive that a command targets
	typedef enum logic {
		dev_floppy = 1'b0,
		dev_hdd    = 1'b1
	} disk_dev_e;

	// Outcome of a disk command, reported back to the CPU
	// as a single-cycle ok or error pulse
	typedef struct packed {
		logic ok;
		logic error;
	} disk_result_t;

	// Map the host's error flag to the pulse pair
	function automatic disk_result_t result_from_err(input logic err);
		disk_result_t res;
		res.ok    = ~err;
		res.error = err;
		return res;
	endfunction

endpackage

// File: rtl/mem_pkg.sv
package mem_pkg;

	// Width of one disk image word on the memory bus
	localparam int MEM_WORD_W = 32;

	typedef logic [MEM_WORD_W-1:0] mem_word_t;

	// DMA bridge FSM
	// st_read_issue and st_write_issue hold the command
	// on the bus until wait_req is low
	typedef enum logic [2:0] {
		st_idle        = 3'd0,
		st_read_issue  = 3'd1,
		st_read_wait   = 3'd2,
		st_write_issue = 3'd3,
		st_ack         = 3'd4
	} bridge_state_e;

	// Any state other than idle counts as busy
	function automatic logic state_busy(input bridge_state_e st);
		return st != st_idle;
	endfunction

endpackage

// File: rtl/mem_if.sv
`timescale 1ns/1ps

interface mem_if #(
	parameter int ADDR_W = 32
) ();

	// Command side, driven by the bridge
	logic [ADDR_W-1:0]  addr;
	mem_pkg::mem_word_t wdata;
	logic               rd;
	logic               we;

	// Response side, driven by the memory
	logic               wait_req;
	mem_pkg::mem_word_t rdata;
	logic               rdata_valid;

	modport bridge (
		output addr,
		output wdata,
		output rd,
		output we,
		input  wait_req,
		input  rdata,
		input  rdata_valid
	);

	// Memory-side view
	modport top (
		input  addr,
		input  wdata,
		input  rd,
		input  we,
		output wait_req,
		output rdata,
		output rdata_valid
	);

endinterface

// File: rtl/reset_seq.sv
`timescale 1ns/1ps

module reset_seq #(
	parameter int RESET_STRETCH = 8
) (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic host_reset,
	input  logic status_reset,
	input  logic button_reset,
	input  logic kbd_reset_n,
	output logic sys_reset,
	output logic cpu_reset
);

	localparam int CNT_W = $clog2(RESET_STRETCH + 1);

	logic [1:0]       status_sync;
	logic             status_prev;
	logic             status_rise;
	logic [CNT_W-1:0] stretch_cnt;
	logic             initialised;
	logic             cpu_rst_q;

	// Edge detect on the synchronised reset bit
	assign status_rise = status_sync[1] & ~status_prev;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			status_sync <= '0;
			status_prev <= 1'b0;
			stretch_cnt <= '0;
			initialised <= 1'b0;
			cpu_rst_q   <= 1'b0;
		end else begin
			status_sync <= {status_sync[0], status_reset};
			status_prev <= status_sync[1];
			cpu_rst_q   <= button_reset | status_reset | ~kbd_reset_n;

			if (status_rise) begin
				stretch_cnt <= CNT_W'(RESET_STRETCH);
				initialised <= 1'b1;
			end else if (stretch_cnt != '0) begin
				stretch_cnt <= stretch_cnt - 1'b1;
			end
		end
	end

	// Held until the host has issued its first reset
	assign sys_reset = (stretch_cnt != '0) | ~initialised | host_reset;
	assign cpu_reset = cpu_rst_q | sys_reset;

endmodule

// File: rtl/dma_bridge.sv
`timescale 1ns/1ps

module dma_bridge #(
	parameter int ADDR_W = 32
) (
	input  logic               clk_sys,
	input  logic               arst_n,

	// Host side, four-phase req/ack
	input  logic               dma_req,
	input  logic               dma_write,
	input  logic [ADDR_W-1:0]  dma_addr,
	input  mem_pkg::mem_word_t dma_wdata,
	output logic               dma_ack,
	output mem_pkg::mem_word_t dma_rdata,

	output logic               busy,

	mem_if.bridge              mem
);

	mem_pkg::bridge_state_e state;

	logic [ADDR_W-1:0]  addr_q;
	mem_pkg::mem_word_t wdata_q;
	mem_pkg::mem_word_t rdata_q;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= mem_pkg::st_idle;
		end else begin
			case (state)
				mem_pkg::st_idle: begin
					if (dma_req) begin
						if (dma_write) begin
							state <= mem_pkg::st_write_issue;
						end else begin
							state <= mem_pkg::st_read_issue;
						end
					end
				end

				// Command stays on the bus while wait_req is high
				mem_pkg::st_read_issue: begin
					if (!mem.wait_req) begin
						state <= mem_pkg::st_read_wait;
					end
				end

				mem_pkg::st_read_wait: begin
					if (mem.rdata_valid) begin
						state <= mem_pkg::st_ack;
					end
				end

				mem_pkg::st_write_issue: begin
					if (!mem.wait_req) begin
						state <= mem_pkg::st_ack;
					end
				end

				// Wait for the host to drop its request
				mem_pkg::st_ack: begin
					if (!dma_req) begin
						state <= mem_pkg::st_idle;
					end
				end

				default: begin
					state <= mem_pkg::st_idle;
				end
			endcase
		end
	end

	// Request payload, captured once per transfer
	always_ff @(posedge clk_sys) begin
		if (state == mem_pkg::st_idle && dma_req) begin
			addr_q  <= dma_addr;
			wdata_q <= dma_wdata;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (state == mem_pkg::st_read_wait && mem.rdata_valid) begin
			rdata_q <= mem.rdata;
		end
	end

	// Bus strobes decode straight from the state register
	assign mem.rd    = (state == mem_pkg::st_read_issue);
	assign mem.we    = (state == mem_pkg::st_write_issue);
	assign mem.addr  = addr_q;
	assign mem.wdata = wdata_q;

	assign dma_ack   = (state == mem_pkg::st_ack);
	assign dma_rdata = rdata_q;
	assign busy      = mem_pkg::state_busy(state);

endmodule

// File: rtl/disk_cmd_tracker.sv
`timescale 1ns/1ps

module disk_cmd_tracker (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  logic                sys_reset,

	// Command pulses from the emulated CPU
	input  logic                disk_rd,
	input  logic                disk_wr,
	input  host_pkg::disk_dev_e disk_device,

	input  logic                bridge_busy,

	// Pending command, visible to the host
	output host_pkg::disk_op_e  disk_op,
	output host_pkg::disk_dev_e disk_op_device,

	// Result handshake from the host
	input  logic                result_req,
	input  logic                result_err,
	output logic                result_ack,
	output logic                cpu_result_ok,
	output logic                cpu_result_error,

	output logic                led_user,
	output logic                led_disk
);

	host_pkg::disk_op_e     op_q;
	host_pkg::disk_dev_e    dev_q;
	host_pkg::disk_result_t res_q;
	logic                   ack_q;
	logic                   pending;

	assign pending = (op_q != host_pkg::op_none);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			op_q  <= host_pkg::op_none;
			dev_q <= host_pkg::dev_floppy;
			res_q <= '0;
			ack_q <= 1'b0;
		end else begin
			res_q <= '0;

			// Only one command at a time, later pulses are dropped
			if (!pending && (disk_rd || disk_wr)) begin
				if (disk_rd) begin
					op_q <= host_pkg::op_read;
				end else begin
					op_q <= host_pkg::op_write;
				end
				dev_q <= disk_device;
			end

			if (result_req && !ack_q) begin
				ack_q <= 1'b1;
				res_q <= host_pkg::result_from_err(result_err);
				op_q  <= host_pkg::op_none;
			end else if (!result_req) begin
				ack_q <= 1'b0;
			end

			// System reset wins over a command arriving in the same cycle
			if (sys_reset) begin
				op_q <= host_pkg::op_none;
			end
		end
	end

	assign disk_op          = op_q;
	assign disk_op_device   = dev_q;
	assign result_ack       = ack_q;
	assign cpu_result_ok    = res_q.ok;
	assign cpu_result_error = res_q.error;

	// Activity LEDs, lit only while a transfer is in flight
	assign led_user = pending & (dev_q == host_pkg::dev_floppy) & bridge_busy;
	assign led_disk = pending & (dev_q == host_pkg::dev_hdd) & bridge_busy;

endmodule

// File: rtl/disk_host_top.sv
`timescale 1ns/1ps

module disk_host_top #(
	parameter int ADDR_W        = 32,
	parameter int RESET_STRETCH = 8
) (
	input  logic                clk_sys,
	input  logic                arst_n,

	// Reset sources
	input  logic                host_reset,
	input  logic                status_reset,
	input  logic                button_reset,
	input  logic                kbd_reset_n,
	output logic                sys_reset,
	output logic                cpu_reset,

	// Host DMA
	input  logic                dma_req,
	input  logic                dma_write,
	input  logic [ADDR_W-1:0]   dma_addr,
	input  mem_pkg::mem_word_t  dma_wdata,
	output logic                dma_ack,
	output mem_pkg::mem_word_t  dma_rdata,

	// Disk commands and results
	input  logic                disk_rd,
	input  logic                disk_wr,
	input  host_pkg::disk_dev_e disk_device,
	output host_pkg::disk_op_e  disk_op,
	output host_pkg::disk_dev_e disk_op_device,
	input  logic                result_req,
	input  logic                result_err,
	output logic                result_ack,
	output logic                cpu_result_ok,
	output logic                cpu_result_error,
	output logic                led_user,
	output logic                led_disk,

	// Main memory
	output logic [ADDR_W-1:0]   mem_addr,
	output mem_pkg::mem_word_t  mem_wdata,
	output logic                mem_rd,
	output logic                mem_we,
	input  logic                mem_wait,
	input  mem_pkg::mem_word_t  mem_rdata,
	input  logic                mem_rdata_valid
);

	logic bridge_busy;

	mem_if #(.ADDR_W(ADDR_W)) mem_bus ();

	assign mem_addr            = mem_bus.addr;
	assign mem_wdata           = mem_bus.wdata;
	assign mem_rd              = mem_bus.rd;
	assign mem_we              = mem_bus.we;
	assign mem_bus.wait_req    = mem_wait;
	assign mem_bus.rdata       = mem_rdata;
	assign mem_bus.rdata_valid = mem_rdata_valid;

	reset_seq #(.RESET_STRETCH(RESET_STRETCH)) i_reset_seq (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.host_reset   (host_reset),
		.status_reset (status_reset),
		.button_reset (button_reset),
		.kbd_reset_n  (kbd_reset_n),
		.sys_reset    (sys_reset),
		.cpu_reset    (cpu_reset)
	);

	dma_bridge #(.ADDR_W(ADDR_W)) i_dma_bridge (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.dma_req   (dma_req),
		.dma_write (dma_write),
		.dma_addr  (dma_addr),
		.dma_wdata (dma_wdata),
		.dma_ack   (dma_ack),
		.dma_rdata (dma_rdata),
		.busy      (bridge_busy),
		.mem       (mem_bus.bridge)
	);

	disk_cmd_tracker i_disk_cmd_tracker (
		.clk_sys          (clk_sys),
		.arst_n           (arst_n),
		.sys_reset        (sys_reset),
		.disk_rd          (disk_rd),
		.disk_wr          (disk_wr),
		.disk_device      (disk_device),
		.bridge_busy      (bridge_busy),
		.disk_op          (disk_op),
		.disk_op_device   (disk_op_device),
		.result_req       (result_req),
		.result_err       (result_err),
		.result_ack       (result_ack),
		.cpu_result_ok    (cpu_result_ok),
		.cpu_result_error (cpu_result_error),
		.led_user         (led_user),
		.led_disk         (led_disk)
	);

endmodule

// File: testbench/disk_host_asserts.sv
`timescale 1ns/1ps

module disk_host_asserts #(
	parameter int ADDR_W = 32
) (
	input logic                   clk_sys,
	input logic                   arst_n,
	input logic                   req,
	input logic                   ack,
	input logic                   rd,
	input logic                   we,
	input logic                   wait_req,
	input mem_pkg::bridge_state_e state,
	input logic [ADDR_W-1:0]      addr,
	input mem_pkg::mem_word_t     wdata
);

	// Number of assertion failures seen so far
	int fail_count = 0;

	ack_after_req: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$rose(ack) |-> req)
		else begin
			fail_count++;
			$error("ack rose without a pending request");
		end

	ack_release: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$fell(req) |=> !ack)
		else begin
			fail_count++;
			$error("ack still high one cycle after the request fell");
		end

	rd_we_exclusive: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(rd && we))
		else begin
			fail_count++;
			$error("rd and we asserted together");
		end

	// Back-pressure freezes the whole command
	cmd_held: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(rd || we) && wait_req |=> $stable(addr) && $stable(wdata) && $stable(state))
		else begin
			fail_count++;
			$error("command changed while wait_req was high");
		end

endmodule

bind dma_bridge disk_host_asserts #(.ADDR_W(ADDR_W)) i_bridge_asserts (
	.clk_sys(clk_sys), .arst_n(arst_n), .req(dma_req), .ack(dma_ack),
	.rd(mem.rd), .we(mem.we), .wait_req(mem.wait_req),
	.state(state), .addr(mem.addr), .wdata(mem.wdata)
);

// The tracker has no memory bus behind its result handshake
bind disk_cmd_tracker disk_host_asserts i_tracker_asserts (
	.clk_sys(clk_sys), .arst_n(arst_n), .req(result_req), .ack(result_ack),
	.rd(1'b0), .we(1'b0), .wait_req(1'b0),
	.state(mem_pkg::st_idle), .addr('0), .wdata('0)
);

// File: testbench/tb_disk_host_top.sv
`timescale 1ns/1ps

module tb_disk_host_top;

	localparam int ADDR_W        = 32;
	localparam int RESET_STRETCH = 8;
	localparam int N_WORDS       = 16;
	localparam int N_XFER        = 2 * N_WORDS + 1;

	logic                clk_sys;
	logic                arst_n;
	logic                host_reset, status_reset, button_reset, kbd_reset_n;
	logic                sys_reset, cpu_reset;
	logic                dma_req, dma_write, dma_ack;
	logic [ADDR_W-1:0]   dma_addr, mem_addr;
	mem_pkg::mem_word_t  dma_wdata, dma_rdata, mem_wdata, mem_rdata;
	logic                disk_rd, disk_wr, result_req, result_err, result_ack;
	logic                cpu_result_ok, cpu_result_error, led_user, led_disk;
	host_pkg::disk_dev_e disk_device, disk_op_device;
	host_pkg::disk_op_e  disk_op;
	logic                mem_rd, mem_we, mem_wait, mem_rdata_valid;

	int                  seed = 33;
	int                  accept_count = 0;
	int                  n_requests = 0;
	mem_pkg::mem_word_t  shadow [logic [ADDR_W-1:0]];
	mem_pkg::mem_word_t  mem_model [logic [ADDR_W-1:0]];
	logic [ADDR_W-1:0]   xfer_addr [N_WORDS];
	mem_pkg::mem_word_t  xfer_data [N_WORDS];
	logic [ADDR_W-1:0]   got_addr_q [$];
	mem_pkg::mem_word_t  got_data_q [$];
	host_pkg::disk_op_e  exp_op;
	host_pkg::disk_dev_e exp_dev;

	disk_host_top #(.ADDR_W(ADDR_W), .RESET_STRETCH(RESET_STRETCH)) i_disk_host_top (.*);

	// Contents of a word never written
	function automatic mem_pkg::mem_word_t fill_word(input logic [ADDR_W-1:0] a);
		return (mem_pkg::mem_word_t'(a) * 32'h9E37_79B1) ^ 32'h5A3C_96E1;
	endfunction

	function automatic mem_pkg::mem_word_t expected_read(input logic [ADDR_W-1:0] a);
		if (shadow.exists(a))
			return shadow[a];
		return fill_word(a);
	endfunction

	// Reset and a result both clear the pending command
	function automatic host_pkg::disk_op_e ref_op(input host_pkg::disk_op_e cur,
			input logic rd, input logic wr, input logic res, input logic srst);
		if (srst || res)
			return host_pkg::op_none;
		if (cur == host_pkg::op_none && rd)
			return host_pkg::op_read;
		if (cur == host_pkg::op_none && wr)
			return host_pkg::op_write;
		return cur;
	endfunction

	function automatic logic ref_led(input host_pkg::disk_op_e op, input host_pkg::disk_dev_e dev,
			input logic busy, input host_pkg::disk_dev_e which);
		return (op != host_pkg::op_none) && (dev == which) && busy;
	endfunction

	function automatic logic ref_cpu_reset(input logic button, input logic status,
			input logic kbd_n, input logic srst);
		return button | status | ~kbd_n | srst;
	endfunction

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_word(input string name, input mem_pkg::mem_word_t got,
			input mem_pkg::mem_word_t exp);
		if (got !== exp)
			stop_on_error($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_op(input string name, input host_pkg::disk_op_e got,
			input host_pkg::disk_op_e exp);
		if (got !== exp)
			stop_on_error($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_dev(input string name, input host_pkg::disk_dev_e got,
			input host_pkg::disk_dev_e exp);
		if (got !== exp)
			stop_on_error($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_leds(input logic busy);
		check_bit("led_disk", led_disk, ref_led(exp_op, exp_dev, busy, host_pkg::dev_hdd));
		check_bit("led_user", led_user, ref_led(exp_op, exp_dev, busy, host_pkg::dev_floppy));
	endtask

	// Raise status_reset and time the stretched sys_reset pulse
	task automatic measure_stretch();
		int rise_wait;
		int high_cnt;
		rise_wait = 0;
		high_cnt = 0;
		@(posedge clk_sys);
		#2;
		status_reset = 1'b1;
		@(negedge clk_sys);
		while (!sys_reset && rise_wait < 4) begin
			rise_wait++;
			@(negedge clk_sys);
		end
		while (sys_reset && high_cnt <= RESET_STRETCH + 4) begin
			high_cnt++;
			@(negedge clk_sys);
		end
		if (high_cnt < RESET_STRETCH)
			stop_on_error("sys_reset was released too early after a status reset");
		if (rise_wait + high_cnt > RESET_STRETCH + 4)
			stop_on_error("sys_reset was not released within the stretch window");
		@(posedge clk_sys);
		#2;
		status_reset = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic cpu_reset_case(input logic button, input logic kbd_n);
		@(posedge clk_sys);
		#2;
		button_reset = button;
		kbd_reset_n  = kbd_n;
		repeat (2) @(negedge clk_sys);
		check_bit("cpu_reset", cpu_reset, ref_cpu_reset(button, 1'b0, kbd_n, 1'b0));
	endtask

	// host_reset drives the system reset without any stretching
	task automatic pulse_host_reset();
		@(posedge clk_sys);
		#2;
		host_reset = 1'b1;
		@(negedge clk_sys);
		check_bit("sys_reset", sys_reset, 1'b1);
		check_bit("cpu_reset", cpu_reset, ref_cpu_reset(button_reset, 1'b0, kbd_reset_n, 1'b1));
		@(posedge clk_sys);
		#2;
		host_reset = 1'b0;
		@(negedge clk_sys);
		check_bit("sys_reset", sys_reset, 1'b0);
		check_bit("cpu_reset", cpu_reset, ref_cpu_reset(button_reset, 1'b0, kbd_reset_n, 1'b0));
	endtask

	task automatic disk_cmd(input logic rd, input host_pkg::disk_dev_e dev);
		@(posedge clk_sys);
		#2;
		disk_rd     = rd;
		disk_wr     = !rd;
		disk_device = dev;
		if (exp_op == host_pkg::op_none)
			exp_dev = dev;
		exp_op = ref_op(exp_op, rd, !rd, 1'b0, 1'b0);
		@(posedge clk_sys);
		#2;
		disk_rd = 1'b0;
		disk_wr = 1'b0;
		@(negedge clk_sys);
		check_op("disk_op", disk_op, exp_op);
		check_dev("disk_op_device", disk_op_device, exp_dev);
	endtask

	task automatic host_result(input logic err);
		@(posedge clk_sys);
		#2;
		result_req = 1'b1;
		result_err = err;
		exp_op = ref_op(exp_op, 1'b0, 1'b0, 1'b1, 1'b0);
		@(negedge clk_sys);
		check_bit("result_ack", result_ack, 1'b0);
		@(negedge clk_sys);
		check_bit("result_ack", result_ack, 1'b1);
		check_bit("cpu_result_ok", cpu_result_ok, !err);
		check_bit("cpu_result_error", cpu_result_error, err);
		check_op("disk_op", disk_op, exp_op);
		@(negedge clk_sys);
		check_bit("cpu_result_ok", cpu_result_ok, 1'b0);
		check_bit("cpu_result_error", cpu_result_error, 1'b0);
		@(posedge clk_sys);
		#2;
		result_req = 1'b0;
		@(negedge clk_sys);
		check_bit("result_ack", result_ack, 1'b1);
		@(negedge clk_sys);
		check_bit("result_ack", result_ack, 1'b0);
	endtask

	task automatic dma_xfer(input logic write, input logic [ADDR_W-1:0] a,
			input mem_pkg::mem_word_t d, output mem_pkg::mem_word_t q);
		@(posedge clk_sys);
		#2;
		dma_write = write;
		dma_addr  = a;
		dma_wdata = d;
		dma_req   = 1'b1;
		n_requests++;
		if (write)
			shadow[a] = d;
		repeat (2) @(negedge clk_sys);
		check_leds(1'b1);
		while (!dma_ack)
			@(negedge clk_sys);
		q = dma_rdata;
		@(posedge clk_sys);
		#2;
		dma_req = 1'b0;
		// Ack is held for one more cycle before the bridge goes idle
		@(negedge clk_sys);
		check_bit("dma_ack", dma_ack, 1'b1);
		@(negedge clk_sys);
		check_bit("dma_ack", dma_ack, 1'b0);
		check_leds(1'b0);
	endtask

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	initial begin
		repeat (N_XFER * 40 + 500) @(posedge clk_sys);
		stop_on_error("Watchdog expired before the test sequence completed");
	end

	initial begin
		wait (i_disk_host_top.i_dma_bridge.i_bridge_asserts.fail_count != 0 ||
			i_disk_host_top.i_disk_cmd_tracker.i_tracker_asserts.fail_count != 0);
		stop_on_error("A handshake assertion in the bound checker failed");
	end

	// Memory with random back-pressure and 1 to 4 cycle read latency
	initial begin : memory_model
		logic               take;
		logic               take_we;
		logic [ADDR_W-1:0]  take_addr;
		mem_pkg::mem_word_t take_data;
		logic [ADDR_W-1:0]  pend_addr;
		int                 lat;
		mem_wait        = 1'b0;
		mem_rdata       = '0;
		mem_rdata_valid = 1'b0;
		lat             = 0;
		forever begin
			// What the DUT samples at the coming edge
			@(negedge clk_sys);
			take      = arst_n && (mem_rd || mem_we) && !mem_wait;
			take_we   = mem_we;
			take_addr = mem_addr;
			take_data = mem_wdata;
			@(posedge clk_sys);
			#2;
			mem_rdata_valid = 1'b0;
			if (lat > 0) begin
				lat--;
				if (lat == 0) begin
					mem_rdata       = mem_model.exists(pend_addr) ? mem_model[pend_addr]
						: fill_word(pend_addr);
					mem_rdata_valid = 1'b1;
				end
			end
			if (take) begin
				accept_count++;
				if (take_we) begin
					mem_model[take_addr] = take_data;
				end else begin
					pend_addr = take_addr;
					lat       = 1 + ({$random(seed)} % 4);
				end
			end
			mem_wait = ({$random(seed)} % 3) == 0;
		end
	end

	initial begin : read_compare
		logic [ADDR_W-1:0]  a;
		mem_pkg::mem_word_t d;
		forever begin
			@(negedge clk_sys);
			while (got_addr_q.size() > 0) begin
				a = got_addr_q.pop_front();
				d = got_data_q.pop_front();
				check_word("dma_rdata", d, expected_read(a));
			end
		end
	end

	initial begin
		mem_pkg::mem_word_t rdata;
		arst_n       = 1'b0;
		host_reset   = 1'b0;
		status_reset = 1'b0;
		button_reset = 1'b0;
		kbd_reset_n  = 1'b1;
		dma_req      = 1'b0;
		dma_write    = 1'b0;
		dma_addr     = '0;
		dma_wdata    = '0;
		disk_rd      = 1'b0;
		disk_wr      = 1'b0;
		disk_device  = host_pkg::dev_floppy;
		result_req   = 1'b0;
		result_err   = 1'b0;
		exp_op       = host_pkg::op_none;
		exp_dev      = host_pkg::dev_floppy;
		for (int i = 0; i < N_WORDS; i++) begin
			xfer_addr[i] = $random(seed);
			xfer_data[i] = $random(seed);
		end
		repeat (2) @(posedge clk_sys);
		#2;
		arst_n = 1'b1;
		@(negedge clk_sys);
		// Held in reset until the host's first status reset
		check_bit("sys_reset", sys_reset, 1'b1);
		check_op("disk_op", disk_op, host_pkg::op_none);
		check_bit("result_ack", result_ack, 1'b0);
		check_bit("dma_ack", dma_ack, 1'b0);
		check_bit("mem_rd", mem_rd, 1'b0);
		check_bit("mem_we", mem_we, 1'b0);
		check_leds(1'b0);

		measure_stretch();
		cpu_reset_case(1'b0, 1'b1);
		cpu_reset_case(1'b1, 1'b1);
		cpu_reset_case(1'b0, 1'b0);
		cpu_reset_case(1'b0, 1'b1);
		pulse_host_reset();

		// Second command is dropped while the first is pending
		disk_cmd(1'b1, host_pkg::dev_hdd);
		disk_cmd(1'b0, host_pkg::dev_floppy);
		for (int i = 0; i < N_WORDS; i++)
			dma_xfer(1'b1, xfer_addr[i], xfer_data[i], rdata);
		host_result(1'b0);

		// Bridge activity alone lights no LED
		dma_xfer(1'b0, xfer_addr[0], '0, rdata);
		got_addr_q.push_back(xfer_addr[0]);
		got_data_q.push_back(rdata);

		disk_cmd(1'b0, host_pkg::dev_floppy);
		for (int i = 0; i < N_WORDS; i++) begin
			dma_xfer(1'b0, xfer_addr[i], '0, rdata);
			got_addr_q.push_back(xfer_addr[i]);
			got_data_q.push_back(rdata);
		end
		host_result(1'b1);

		// A status reset clears a pending command
		disk_cmd(1'b1, host_pkg::dev_floppy);
		measure_stretch();
		exp_op = ref_op(exp_op, 1'b0, 1'b0, 1'b0, 1'b1);
		check_op("disk_op", disk_op, exp_op);

		while (got_addr_q.size() != 0)
			@(negedge clk_sys);
		check_word("accept_count", accept_count, n_requests);
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: all.f
rtl/host_pkg.sv
rtl/mem_pkg.sv
rtl/mem_if.sv
rtl/reset_seq.sv
rtl/dma_bridge.sv
rtl/disk_cmd_tracker.sv
rtl/disk_host_top.sv
testbench/disk_host_asserts.sv
testbench/tb_disk_host_top.sv
